/* branchControl.sv */
`timescale 1ns/1ns

module branchControl (
  input  logic                clock,
  input  logic                arstN,
  input  logic                stall,
  input  logic                flush,
  input  logic                flag,
  input  idecPkg::decodedOp_t decoded,
  output logic                jump,
  output logic                isDelaySlot
);

  logic               isJumpReg;
  idecPkg::jumpCond_e jumpCondReg;
  logic               condMet;

  // tracks the jump sitting in execute
  always_ff @(posedge clock or negedge arstN)
  begin
    if (!arstN)
    begin
      isJumpReg   <= 1'b0;
      jumpCondReg <= idecPkg::JumpAlways;
    end
    else if (!stall)
    begin
      isJumpReg   <= decoded.isJump & ~flush;
      jumpCondReg <= decoded.jumpCond;
    end
  end

  always_comb
  begin
    case (jumpCondReg)
      idecPkg::JumpAlways:    condMet = 1'b1;
      idecPkg::JumpFlagClear: condMet = ~flag;
      idecPkg::JumpFlagSet:   condMet = flag;
      default:                condMet = 1'b0;
    endcase
  end

  assign jump = isJumpReg & ~stall & ~flush & condMet;

  // a jump now in execute makes the instruction being captured its delay slot
  assign isDelaySlot = isJumpReg;

endmodule

/* decodeStage.f */
idecPkg.sv
opcodeDecoder.sv
operandSelect.sv
branchControl.sv
executeRegister.sv
decodeStage.sv
decodeStage_sva.sv
decodeStageTb.sv

/* decodeStage.sv */
`timescale 1ns/1ns

module decodeStage (
  input  logic                             clock,
  input  logic                             arstN,
  input  logic                             stall,
  input  logic                             flush,
  input  logic [idecPkg::WordWidth-1:0]    ir,
  input  logic [idecPkg::WordWidth-1:0]    pc,
  input  logic [idecPkg::WordWidth-1:0]    rfOperandA,
  input  logic [idecPkg::WordWidth-1:0]    rfOperandB,
  input  logic [idecPkg::WordWidth-1:0]    forwardedOperandA,
  input  logic [idecPkg::WordWidth-1:0]    forwardedOperandB,
  input  logic [idecPkg::WordWidth-1:0]    forwardedStoreData,
  input  logic                             useForwardedA,
  input  logic                             useForwardedB,
  input  logic                             useForwardedStore,
  input  logic                             flag,
  output logic [idecPkg::RegAddrWidth-1:0] lookupAddrA,
  output logic [idecPkg::RegAddrWidth-1:0] lookupAddrB,
  output logic                             jump,
  output idecPkg::exeBundle_t              exe
);

  idecPkg::decodedOp_t           decoded;
  logic [idecPkg::WordWidth-1:0] operandA;
  logic [idecPkg::WordWidth-1:0] operandB;
  logic [idecPkg::WordWidth-1:0] storeData;
  logic                          isDelaySlot;

  // register file read addresses go out straight from the instruction word
  assign lookupAddrA = ir[20:16];
  assign lookupAddrB = ir[15:11];

  opcodeDecoder decoder (
    .ir      (ir),
    .decoded (decoded)
  );

  operandSelect operands (
    .ir                 (ir),
    .pc                 (pc),
    .decoded            (decoded),
    .rfOperandA         (rfOperandA),
    .rfOperandB         (rfOperandB),
    .forwardedOperandA  (forwardedOperandA),
    .forwardedOperandB  (forwardedOperandB),
    .forwardedStoreData (forwardedStoreData),
    .useForwardedA      (useForwardedA),
    .useForwardedB      (useForwardedB),
    .useForwardedStore  (useForwardedStore),
    .operandA           (operandA),
    .operandB           (operandB),
    .storeData          (storeData)
  );

  branchControl branch (
    .clock       (clock),
    .arstN       (arstN),
    .stall       (stall),
    .flush       (flush),
    .flag        (flag),
    .decoded     (decoded),
    .jump        (jump),
    .isDelaySlot (isDelaySlot)
  );

  executeRegister exeStage (
    .clock       (clock),
    .arstN       (arstN),
    .stall       (stall),
    .flush       (flush),
    .decoded     (decoded),
    .operandA    (operandA),
    .operandB    (operandB),
    .storeData   (storeData),
    .pc          (pc),
    .isDelaySlot (isDelaySlot),
    .exe         (exe)
  );

endmodule

/* decodeStageTb.sv */
`timescale 1ns/1ns

module decodeStageTb;

  localparam int NumTests     = 33;
  localparam int WordsPerTest = 14;
  localparam int ResetTimeout = 10;

  logic                             clock;
  logic                             arstN;
  logic                             stall;
  logic                             flush;
  logic [idecPkg::WordWidth-1:0]    ir;
  logic [idecPkg::WordWidth-1:0]    pc;
  logic [idecPkg::WordWidth-1:0]    rfOperandA;
  logic [idecPkg::WordWidth-1:0]    rfOperandB;
  logic [idecPkg::WordWidth-1:0]    forwardedOperandA;
  logic [idecPkg::WordWidth-1:0]    forwardedOperandB;
  logic [idecPkg::WordWidth-1:0]    forwardedStoreData;
  logic                             useForwardedA;
  logic                             useForwardedB;
  logic                             useForwardedStore;
  logic                             flag;
  logic [idecPkg::RegAddrWidth-1:0] lookupAddrA;
  logic [idecPkg::RegAddrWidth-1:0] lookupAddrB;
  logic                             jump;
  idecPkg::exeBundle_t              exe;

  logic [31:0] vectors [NumTests*WordsPerTest];
  logic        testOk [NumTests];
  int          passCount = 0;
  int          errorCount = 0;
  logic [31:0] heldStoreData = '0;
  logic [31:0] heldAddress = '0;

  decodeStage DUT (.*);

  bind decodeStage decodeStageSva sva (
    .clock (clock),
    .arstN (arstN),
    .stall (stall),
    .flush (flush),
    .jump  (jump),
    .exe   (exe)
  );

  initial
  begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // columns 0..8 are stimulus, 9..13 the expected operandA, operandB, dest, control, jump
  function automatic logic [31:0] field(input int t, input int column);
    return vectors[t*WordsPerTest + column];
  endfunction

  function automatic logic [31:0] controlWord(input idecPkg::exeBundle_t e);
    return {20'd0, e.valid, e.active, e.weDestination, e.isLoad, e.isStore,
            e.isJump, e.isDelaySlot, 1'b0, 4'(e.aluFunc)};
  endfunction

  function automatic logic resetIdle();
    return exe.valid && !exe.active && !exe.weDestination && !exe.isLoad &&
           !exe.isStore && !exe.isJump && !exe.isDelaySlot && !jump;
  endfunction

  task automatic applyVector(input int t);
    logic [31:0] ctrl;
    logic [31:0] stallFlush;
    ctrl       = field(t, 7);
    stallFlush = field(t, 8);
    ir                 <= field(t, 0);
    pc                 <= field(t, 1);
    rfOperandA         <= field(t, 2);
    rfOperandB         <= field(t, 3);
    // unused forwarded values get noise
    forwardedOperandA  <= ctrl[3] ? field(t, 4) : $urandom;
    forwardedOperandB  <= ctrl[2] ? field(t, 5) : $urandom;
    forwardedStoreData <= ctrl[1] ? field(t, 6) : $urandom;
    useForwardedA      <= ctrl[3];
    useForwardedB      <= ctrl[2];
    useForwardedStore  <= ctrl[1];
    flag               <= ctrl[0];
    stall              <= stallFlush[1];
    flush              <= stallFlush[0];
  endtask

  task automatic checkValue(input int t, input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    assert (actual === expected)
    else
    begin
      $display("mismatch test %0d %s: got %h, expected %h", t, name, actual, expected);
      testOk[t] = 1'b0;
    end
  endtask

  task automatic checkLookup(input int t);
    logic [31:0] word;
    word = field(t, 0);
    checkValue(t, "lookupAddrA", {27'd0, lookupAddrA}, {27'd0, word[20:16]});
    checkValue(t, "lookupAddrB", {27'd0, lookupAddrB}, {27'd0, word[15:11]});
  endtask

  task automatic checkExe(input int t);
    logic [31:0] ctrl;
    logic [31:0] stallFlush;
    ctrl       = field(t, 7);
    stallFlush = field(t, 8);
    // a stalled capture keeps the earlier data
    if (!stallFlush[1])
    begin
      heldAddress   = field(t, 1);
      heldStoreData = ctrl[1] ? field(t, 6) : field(t, 3);
    end
    checkValue(t, "exe.operandA", exe.operandA, field(t, 9));
    checkValue(t, "exe.operandB", exe.operandB, field(t, 10));
    checkValue(t, "exe.destination", {27'd0, exe.destination}, field(t, 11));
    checkValue(t, "exe control", controlWord(exe), field(t, 12));
    checkValue(t, "exe.storeData", exe.storeData, heldStoreData);
    checkValue(t, "exe.instructionAddress", exe.instructionAddress, heldAddress);
  endtask

  task automatic reportTest(input int t);
    if (testOk[t])
    begin
      passCount++;
      $display("test %0d: pass", t);
    end
    else
    begin
      errorCount++;
      $display("test %0d: error", t);
    end
  endtask

  initial
  begin
    int  waitCycles;
    logic vectorsOk;
    void'($urandom(32'h1080));
    arstN              <= 1'b0;
    stall              <= 1'b0;
    flush              <= 1'b0;
    ir                 <= 32'h1500_0000;
    pc                 <= '0;
    rfOperandA         <= '0;
    rfOperandB         <= '0;
    forwardedOperandA  <= '0;
    forwardedOperandB  <= '0;
    forwardedStoreData <= '0;
    useForwardedA      <= 1'b0;
    useForwardedB      <= 1'b0;
    useForwardedStore  <= 1'b0;
    flag               <= 1'b0;
    for (int i = 0; i < NumTests*WordsPerTest; i++)
      vectors[i] = 32'hBAD0_0000 | 32'(i);
    $readmemh("decodeStageTests.txt", vectors);
    vectorsOk = 1'b1;
    for (int t = 0; t < NumTests; t++)
    begin
      testOk[t] = 1'b1;
      if (field(t, 13) > 32'd1)
        vectorsOk = 1'b0;
    end
    if (!vectorsOk)
    begin
      $display("test vector file is missing or incomplete");
      $display("Something failed");
      $finish;
    end
    else
    begin
      repeat (2) @(posedge clock);
      arstN <= 1'b1;
      waitCycles = 0;
      @(negedge clock);
      while (!resetIdle() && waitCycles < ResetTimeout)
      begin
        @(negedge clock);
        waitCycles++;
      end
      if (!resetIdle())
      begin
        $display("timed out waiting for an idle execute bundle after reset");
        $display("Something failed");
        $finish;
      end
      else
      begin
        passCount++;
        $display("reset: pass");
        // jump for a vector shows before its capture and exe one edge later
        for (int t = 0; t <= NumTests; t++)
        begin
          @(posedge clock);
          if (t < NumTests)
            applyVector(t);
          @(negedge clock);
          if (t < NumTests)
          begin
            checkValue(t, "jump", {31'd0, jump}, field(t, 13));
            checkLookup(t);
          end
          if (t > 0)
          begin
            checkExe(t - 1);
            reportTest(t - 1);
          end
        end
        $display("%0d tests run, %0d passed, %0d with errors",
                 passCount + errorCount, passCount, errorCount);
        if (errorCount == 0)
          $display("Everything OK");
        else
          $display("Something failed");
        $finish;
      end
    end
  end

endmodule

/* decodeStageTests.txt */
// ir pc rfA rfB fwdA fwdB fwdStore ctrl(useFwdA,useFwdB,useFwdStore,flag) stall/flush
// then expected: operandA operandB destination control(valid..delaySlot,aluFunc) jump
E0611000 1000 11111111 22222222 0 0 0 0 0 11111111 22222222 3 E00 0
E0811002 1004 33333333 44444444 0 0 0 0 0 33333333 44444444 4 E02 0
E0A11803 1008 0F0F0F0F 00FF00FF 0 0 0 0 0 0F0F0F0F 00FF00FF 5 E03 0
E0221804 100C 12345678 9ABCDEF0 0 0 0 0 0 12345678 9ABCDEF0 1 E04 0
E0611005 1010 55555555 66666666 0 0 0 0 0 55555555 66666666 3 0 0
FC611000 1014 77777777 88888888 0 0 0 0 0 77777777 88888888 3 0 0
15000000 1018 99999999 AAAAAAAA 0 0 0 0 0 0 0 8 800 0
9C61FFF0 101C 100 BBBBBBBB 0 0 0 0 0 100 FFFFFFF0 3 E00 0
A4418001 1020 CCCCCCCC DDDDDDDD 0 0 0 0 0 CCCCCCCC 8001 2 E03 0
A8821234 1024 FF00 EEEEEEEE 0 0 0 0 0 FF00 1234 4 E04 0
18A0ABCD 1028 13579BDF 2468ACE0 0 0 0 0 0 0 ABCD0000 5 E00 0
84610008 102C 2000 0 0 0 0 0 0 2000 8 3 F00 0
8401FFFC 1030 3000 0 0 0 0 0 0 3000 FFFFFFFC 0 E00 0
D6011004 1034 4000 5A5A5A5A 0 0 C3C3C3C3 2 0 4000 FFFF8004 10 C80 0
E0601000 1038 11110000 22220000 AAAA0000 BBBB0000 0 C 0 0 BBBB0000 3 E00 0
E0610000 103C 11110000 22220000 AAAA1111 BBBB1111 0 C 0 AAAA1111 0 3 E00 0
E0811000 1040 11112222 22223333 AAAA2222 0 0 8 0 AAAA2222 22223333 4 E00 0
9C220005 1044 50 0 0 0 0 0 0 50 5 1 E00 0
E0A11804 1048 DEADBEEF CAFEF00D 0 0 0 0 2 50 5 1 E00 0
E0611002 104C 01010101 02020202 0 0 0 0 2 50 5 1 E00 0
E0611000 1050 31313131 42424242 0 0 0 0 1 31313131 42424242 3 800 0
A8821234 1054 53535353 0 0 0 0 0 1 53535353 1234 4 804 0
10000010 1058 0 0 0 0 0 0 0 1058 40 0 C40 0
E0611000 105C 64646464 75757575 0 0 0 1 0 64646464 75757575 3 E20 1
0FFFFFFE 1060 0 0 0 0 0 1 0 1060 FFFFFFF8 1F C40 0
15000000 1064 0 0 0 0 0 1 0 0 0 8 820 0
00000100 1068 0 0 0 0 0 0 0 1068 400 0 C40 0
E0221804 106C 86868686 97979797 0 0 0 0 2 1068 400 0 C40 0
E0221804 1070 86868686 97979797 0 0 0 0 0 86868686 97979797 1 E24 1
04000020 1074 0 0 0 0 0 1 0 1074 80 9 E40 0
E0611000 1078 A8A8A8A8 B9B9B9B9 0 0 0 1 1 A8A8A8A8 B9B9B9B9 3 800 0
0C000004 107C 0 0 0 0 0 0 1 107C 10 0 800 0
E0611000 1080 CACACACA DBDBDBDB 0 0 0 0 0 CACACACA DBDBDBDB 3 E00 0

/* decodeStage_sva.sv */
`timescale 1ns/1ns

module decodeStageSva (
  input logic                clock,
  input logic                arstN,
  input logic                stall,
  input logic                flush,
  input logic                jump,
  input idecPkg::exeBundle_t exe
);

  // the execute bundle freezes while decode is held
  stallHolds: assert property (
    @(posedge clock) disable iff (!arstN)
    stall |=> $stable(exe)
  )
  else $error("exe changed after a stall cycle");

  // a flushed slot never writes a register
  flushClearsWrite: assert property (
    @(posedge clock) disable iff (!arstN)
    (flush && !stall) |=> !exe.weDestination
  )
  else $error("weDestination set after a flush");

  // jump only fires for a jump sitting in execute
  stallBlocksJump: assert property (
    @(posedge clock) disable iff (!arstN)
    (stall || !exe.isJump) |-> !jump
  )
  else $error("jump raised while stalled or with no jump in execute");

endmodule

/* executeRegister.sv */
`timescale 1ns/1ns

module executeRegister (
  input  logic                          clock,
  input  logic                          arstN,
  input  logic                          stall,
  input  logic                          flush,
  input  idecPkg::decodedOp_t           decoded,
  input  logic [idecPkg::WordWidth-1:0] operandA,
  input  logic [idecPkg::WordWidth-1:0] operandB,
  input  logic [idecPkg::WordWidth-1:0] storeData,
  input  logic [idecPkg::WordWidth-1:0] pc,
  input  logic                          isDelaySlot,
  output idecPkg::exeBundle_t           exe
);

  logic [idecPkg::WordWidth-1:0]    operandAReg;
  logic [idecPkg::WordWidth-1:0]    operandBReg;
  logic [idecPkg::WordWidth-1:0]    storeDataReg;
  logic [idecPkg::WordWidth-1:0]    addressReg;
  logic [idecPkg::RegAddrWidth-1:0] destinationReg;
  idecPkg::aluFunc_e                aluFuncReg;
  logic                             weReg;
  logic                             loadReg;
  logic                             storeReg;
  logic                             validReg;
  logic                             activeReg;
  logic                             jumpReg;
  logic                             delaySlotReg;

  always_ff @(posedge clock)
  begin
    if (!stall)
    begin
      operandAReg    <= operandA;
      operandBReg    <= operandB;
      storeDataReg   <= storeData;
      addressReg     <= pc;
      destinationReg <= decoded.destination;
      aluFuncReg     <= decoded.aluFunc;
    end
  end

  // a flushed slot becomes a valid but inactive bubble
  always_ff @(posedge clock or negedge arstN)
  begin
    if (!arstN)
    begin
      weReg        <= 1'b0;
      loadReg      <= 1'b0;
      storeReg     <= 1'b0;
      validReg     <= 1'b1;
      activeReg    <= 1'b0;
      jumpReg      <= 1'b0;
      delaySlotReg <= 1'b0;
    end
    else if (!stall)
    begin
      weReg        <= decoded.weDestination & ~flush;
      loadReg      <= decoded.isLoad & ~flush;
      storeReg     <= decoded.isStore & ~flush;
      validReg     <= decoded.valid | flush;
      activeReg    <= decoded.active & ~flush;
      jumpReg      <= decoded.isJump & ~flush;
      delaySlotReg <= isDelaySlot & ~flush;
    end
  end

  assign exe = '{
    operandA:           operandAReg,
    operandB:           operandBReg,
    storeData:          storeDataReg,
    instructionAddress: addressReg,
    destination:        destinationReg,
    weDestination:      weReg,
    isLoad:             loadReg,
    isStore:            storeReg,
    aluFunc:            aluFuncReg,
    valid:              validReg,
    active:             activeReg,
    isJump:             jumpReg,
    isDelaySlot:        delaySlotReg
  };

endmodule

/* idecPkg.sv */
package idecPkg;

  localparam int WordWidth    = 32;
  localparam int RegAddrWidth = 5;

  // jal writes its return address here
  localparam logic [RegAddrWidth-1:0] LinkRegister = 5'd9;

  // nop is recognised on the whole top byte, not only the major opcode
  localparam logic [7:0] NopTopByte = 8'h15;

  typedef enum logic [5:0] {
    OpJ     = 6'h00,
    OpJal   = 6'h01,
    OpBnf   = 6'h03,
    OpBf    = 6'h04,
    OpNop   = 6'h05,
    OpMovhi = 6'h06,
    OpLwz   = 6'h21,
    OpAddi  = 6'h27,
    OpAndi  = 6'h29,
    OpOri   = 6'h2A,
    OpSw    = 6'h35,
    OpAlu   = 6'h38
  } opcode_e;

  typedef enum logic [3:0] {
    FuncAdd = 4'h0,
    FuncSub = 4'h2,
    FuncAnd = 4'h3,
    FuncOr  = 4'h4
  } aluFunc_e;

  typedef enum logic [2:0] {
    ImmSignHalf,
    ImmZeroHalf,
    ImmHighHalf,
    ImmBranch,
    ImmStoreSplit
  } immFormat_e;

  typedef enum logic [1:0] {
    JumpAlways,
    JumpFlagClear,
    JumpFlagSet
  } jumpCond_e;

  typedef struct packed {
    logic                    valid;
    logic                    active;
    logic                    usePc;
    logic                    useImmediate;
    immFormat_e              immFormat;
    logic                    isJump;
    jumpCond_e               jumpCond;
    logic [RegAddrWidth-1:0] destination;
    logic                    weDestination;
    logic                    isLoad;
    logic                    isStore;
    aluFunc_e                aluFunc;
  } decodedOp_t;

  typedef struct packed {
    logic [WordWidth-1:0]    operandA;
    logic [WordWidth-1:0]    operandB;
    logic [WordWidth-1:0]    storeData;
    logic [WordWidth-1:0]    instructionAddress;
    logic [RegAddrWidth-1:0] destination;
    logic                    weDestination;
    logic                    isLoad;
    logic                    isStore;
    aluFunc_e                aluFunc;
    logic                    valid;
    logic                    active;
    logic                    isJump;
    logic                    isDelaySlot;
  } exeBundle_t;

endpackage

/* opcodeDecoder.sv */
`timescale 1ns/1ns

module opcodeDecoder (
  input  logic [idecPkg::WordWidth-1:0] ir,
  output idecPkg::decodedOp_t           decoded
);

  logic aluFuncKnown;

  assign aluFuncKnown = (ir[3:0] == idecPkg::FuncAdd) || (ir[3:0] == idecPkg::FuncSub) ||
                        (ir[3:0] == idecPkg::FuncAnd) || (ir[3:0] == idecPkg::FuncOr);

  always_comb
  begin
    decoded             = '0;
    decoded.destination = ir[25:21];
    decoded.immFormat   = idecPkg::ImmSignHalf;
    decoded.jumpCond    = idecPkg::JumpAlways;
    decoded.aluFunc     = idecPkg::FuncAdd;
    case (idecPkg::opcode_e'(ir[31:26]))
      idecPkg::OpJ, idecPkg::OpJal, idecPkg::OpBnf, idecPkg::OpBf:
      begin
        decoded.valid        = 1'b1;
        decoded.usePc        = 1'b1;
        decoded.useImmediate = 1'b1;
        decoded.immFormat    = idecPkg::ImmBranch;
        decoded.isJump       = 1'b1;
        if (ir[31:26] == idecPkg::OpBnf)
          decoded.jumpCond = idecPkg::JumpFlagClear;
        else if (ir[31:26] == idecPkg::OpBf)
          decoded.jumpCond = idecPkg::JumpFlagSet;
        if (ir[31:26] == idecPkg::OpJal)
        begin
          decoded.destination   = idecPkg::LinkRegister;
          decoded.weDestination = 1'b1;
        end
      end
      idecPkg::OpNop:
        decoded.valid = (ir[31:24] == idecPkg::NopTopByte);
      idecPkg::OpMovhi:
      begin
        decoded.valid         = 1'b1;
        decoded.useImmediate  = 1'b1;
        decoded.immFormat     = idecPkg::ImmHighHalf;
        decoded.weDestination = 1'b1;
      end
      idecPkg::OpAddi, idecPkg::OpAndi, idecPkg::OpOri:
      begin
        decoded.valid         = 1'b1;
        decoded.useImmediate  = 1'b1;
        decoded.weDestination = 1'b1;
        if (ir[31:26] == idecPkg::OpAndi)
        begin
          decoded.immFormat = idecPkg::ImmZeroHalf;
          decoded.aluFunc   = idecPkg::FuncAnd;
        end
        else if (ir[31:26] == idecPkg::OpOri)
        begin
          decoded.immFormat = idecPkg::ImmZeroHalf;
          decoded.aluFunc   = idecPkg::FuncOr;
        end
      end
      idecPkg::OpLwz:
      begin
        decoded.valid         = 1'b1;
        decoded.useImmediate  = 1'b1;
        decoded.weDestination = 1'b1;
        // a load into r0 is dropped
        decoded.isLoad        = (ir[25:21] != '0);
      end
      idecPkg::OpSw:
      begin
        decoded.valid        = 1'b1;
        decoded.useImmediate = 1'b1;
        decoded.immFormat    = idecPkg::ImmStoreSplit;
        decoded.isStore      = 1'b1;
      end
      idecPkg::OpAlu:
      begin
        decoded.valid         = aluFuncKnown;
        decoded.weDestination = aluFuncKnown;
        if (aluFuncKnown)
          decoded.aluFunc = idecPkg::aluFunc_e'(ir[3:0]);
      end
      default:
        decoded.valid = 1'b0;
    endcase
    decoded.active = decoded.valid && (ir[31:24] != idecPkg::NopTopByte);
  end

endmodule

/* operandSelect.sv */
`timescale 1ns/1ns

module operandSelect (
  input  logic [idecPkg::WordWidth-1:0] ir,
  input  logic [idecPkg::WordWidth-1:0] pc,
  input  idecPkg::decodedOp_t           decoded,
  input  logic [idecPkg::WordWidth-1:0] rfOperandA,
  input  logic [idecPkg::WordWidth-1:0] rfOperandB,
  input  logic [idecPkg::WordWidth-1:0] forwardedOperandA,
  input  logic [idecPkg::WordWidth-1:0] forwardedOperandB,
  input  logic [idecPkg::WordWidth-1:0] forwardedStoreData,
  input  logic                          useForwardedA,
  input  logic                          useForwardedB,
  input  logic                          useForwardedStore,
  output logic [idecPkg::WordWidth-1:0] operandA,
  output logic [idecPkg::WordWidth-1:0] operandB,
  output logic [idecPkg::WordWidth-1:0] storeData
);

  logic [idecPkg::WordWidth-1:0] immediate;

  always_comb
  begin
    case (decoded.immFormat)
      idecPkg::ImmZeroHalf:   immediate = {16'd0, ir[15:0]};
      idecPkg::ImmHighHalf:   immediate = {ir[15:0], 16'd0};
      idecPkg::ImmBranch:     immediate = {{4{ir[25]}}, ir[25:0], 2'b00};
      // store offset is split around the rB field
      idecPkg::ImmStoreSplit: immediate = {{16{ir[25]}}, ir[25:21], ir[10:0]};
      default:                immediate = {{16{ir[15]}}, ir[15:0]};
    endcase
  end

  always_comb
  begin
    if (decoded.usePc)
      operandA = pc;
    else if (ir[20:16] == '0)
      operandA = '0;
    else if (useForwardedA)
      operandA = forwardedOperandA;
    else
      operandA = rfOperandA;

    if (decoded.useImmediate)
      operandB = immediate;
    else if (ir[15:11] == '0)
      operandB = '0;
    else if (useForwardedB)
      operandB = forwardedOperandB;
    else
      operandB = rfOperandB;
  end

  assign storeData = useForwardedStore ? forwardedStoreData : rfOperandB;

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module decodeStageTb -f decodeStage.f
status=0
./obj_dir/VdecodeStageTb > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q "Something failed" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
echo "simulation passed"
